/* logic/irq_offload_pkg.sv */
package irq_offload_pkg;

    // ------------------------------------------------------------
    // Bus words
    // ------------------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // Single-access register bus operation
    typedef enum logic {
        LITE_READ  = 1'b0,
        LITE_WRITE = 1'b1
    } lite_op_t;

    // One register-bus request, 65 bits
    typedef struct packed {
        lite_op_t op;
        addr_t    addr;
        data_t    data;
    } lite_req_t;

    // ------------------------------------------------------------
    // Wireless chip register offsets
    // ------------------------------------------------------------
    localparam addr_t AR_IER    = 32'h0000_0024;
    localparam addr_t AR_ISR    = 32'h0000_0080;
    // Per-QCU TX-OK status
    localparam addr_t AR_ISR_S0 = 32'h0000_0084;

    // PCIe controller interrupt registers
    localparam addr_t PCIE_INT_DECODE    = 32'h0000_0138;
    localparam addr_t PCIE_INT_FIFO_REG1 = 32'h0000_0158;

    // ------------------------------------------------------------
    // Interrupt cause bits in ISR
    // ------------------------------------------------------------
    localparam data_t ISR_HP_RXOK = 32'h0000_0001;
    localparam data_t ISR_LP_RXOK = 32'h0000_0002;
    localparam data_t ISR_TXOK    = 32'h0000_0040;
    localparam data_t ISR_RXMINTR = 32'h0100_0000;
    localparam data_t ISR_RXINTM  = 32'h8000_0000;

    // ------------------------------------------------------------
    // Fixed write values
    // ------------------------------------------------------------
    localparam data_t IER_ENABLE  = 32'h0000_0001;
    localparam data_t IER_DISABLE = 32'h0000_0000;

    // Acknowledge values for the PCIe interrupt registers
    localparam data_t PCIE_DECODE_ACK = 32'h0001_0000;
    localparam data_t PCIE_FIFO_ACK   = 32'hffff_ffff;

endpackage

/* logic/lite_bus_arbiter.sv */
module lite_bus_arbiter
    import irq_offload_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    // Requesters, highest priority first
    input  logic      irq_req,
    input  logic      txf_req,
    input  logic      pirq_req,
    input  lite_req_t irq_req_data,
    input  lite_req_t txf_req_data,
    input  lite_req_t pirq_req_data,
    output logic      irq_grant,
    output logic      txf_grant,
    output logic      pirq_grant,
    output logic      irq_done,
    output logic      txf_done,
    output logic      pirq_done,
    // External register bus
    output lite_req_t lite_req,
    output logic      lite_start,
    input  logic      lite_idle,
    input  logic      lite_done
);

    typedef enum logic {
        ARB_IDLE,
        ARB_WAIT
    } arb_state_t;

    arb_state_t state;
    // One-hot, bit 0 is the ISR handler
    logic [2:0] pick;
    logic [2:0] owner;
    logic       can_issue;
    lite_req_t  sel_data;

    // Fixed priority select
    always_comb begin
        pick = 3'b000;
        sel_data = pirq_req_data;
        if (irq_req) begin
            pick = 3'b001;
            sel_data = irq_req_data;
        end else if (txf_req) begin
            pick = 3'b010;
            sel_data = txf_req_data;
        end else if (pirq_req) begin
            pick = 3'b100;
        end
    end

    assign can_issue = (state == ARB_IDLE) && lite_idle && (pick != 3'b000);

    assign irq_grant  = can_issue & pick[0];
    assign txf_grant  = can_issue & pick[1];
    assign pirq_grant = can_issue & pick[2];

    // Completion goes back to whoever owns the bus
    assign irq_done  = (state == ARB_WAIT) & lite_done & owner[0];
    assign txf_done  = (state == ARB_WAIT) & lite_done & owner[1];
    assign pirq_done = (state == ARB_WAIT) & lite_done & owner[2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ARB_IDLE;
            lite_start <= 1'b0;
            owner <= 3'b000;
        end else begin
            lite_start <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (can_issue) begin
                        lite_start <= 1'b1;
                        owner <= pick;
                        state <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (lite_done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Request is held on the bus until the next grant
    always_ff @(posedge clk) begin
        if (can_issue) begin
            lite_req <= sel_data;
        end
    end

endmodule

/* logic/isr_handler.sv */
module isr_handler
    import irq_offload_pkg::*;
#(
    parameter addr_t CHIP_BASE = 32'h6000_0000,
    parameter data_t FPGA_QCU  = 32'h0000_0040
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      irq_in,
    output logic      irq_out,
    // Register bus request path
    output logic      req,
    output lite_req_t req_data,
    input  logic      grant,
    input  logic      done,
    input  data_t     rdata,
    // PCIe acknowledge handshake
    output logic      clear_start,
    input  logic      clear_done
);

    typedef enum logic [3:0] {
        ISR_IDLE,
        ISR_RD_ISR,
        ISR_RD_S0,
        ISR_JUDGE,
        ISR_DISABLE,
        ISR_CLEAR,
        ISR_ENABLE,
        ISR_PCIE,
        ISR_PASS
    } isr_state_t;

    // RX causes the FPGA consumes as a group
    localparam data_t RX_CAUSES = ISR_HP_RXOK | ISR_RXINTM | ISR_RXMINTR;

    isr_state_t state;
    data_t      isr_val;
    logic       txok_own;
    logic       hp_rxok;
    logic       rxhp_only;
    logic       owned;
    logic       own_match;
    data_t      clear_mask;

    // ------------------------------------------------------------
    // Ownership decision and clear mask
    // ------------------------------------------------------------
    always_comb begin
        clear_mask = '0;
        if (txok_own) begin
            clear_mask = clear_mask | ISR_TXOK;
        end
        if (hp_rxok) begin
            clear_mask = clear_mask | ISR_HP_RXOK;
        end
        if (rxhp_only) begin
            clear_mask = clear_mask | ISR_RXINTM | ISR_RXMINTR;
        end
    end

    // Only exact cause sets belong to the FPGA
    assign own_match = (hp_rxok && (isr_val == RX_CAUSES))
                    || (txok_own && (isr_val == (RX_CAUSES | ISR_TXOK)))
                    || (txok_own && (isr_val == ISR_TXOK));

    // Request payload follows the bus step
    always_comb begin
        req_data.op = LITE_WRITE;
        req_data.addr = CHIP_BASE + AR_ISR;
        req_data.data = clear_mask;
        case (state)
            ISR_RD_ISR: begin
                req_data.op = LITE_READ;
                req_data.data = '0;
            end
            ISR_RD_S0: begin
                req_data.op = LITE_READ;
                req_data.addr = CHIP_BASE + AR_ISR_S0;
                req_data.data = '0;
            end
            ISR_DISABLE: begin
                req_data.addr = CHIP_BASE + AR_IER;
                req_data.data = IER_DISABLE;
            end
            ISR_ENABLE: begin
                req_data.addr = CHIP_BASE + AR_IER;
                req_data.data = IER_ENABLE;
            end
            default: begin
            end
        endcase
    end

    // ------------------------------------------------------------
    // Interrupt FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ISR_IDLE;
            req <= 1'b0;
            irq_out <= 1'b0;
            clear_start <= 1'b0;
            isr_val <= '0;
            txok_own <= 1'b0;
            hp_rxok <= 1'b0;
            rxhp_only <= 1'b0;
            owned <= 1'b0;
        end else begin
            clear_start <= 1'b0;
            if (grant) begin
                req <= 1'b0;
            end
            case (state)
                ISR_IDLE: begin
                    if (irq_in) begin
                        txok_own <= 1'b0;
                        req <= 1'b1;
                        state <= ISR_RD_ISR;
                    end
                end
                ISR_RD_ISR: begin
                    if (done) begin
                        isr_val <= rdata;
                        hp_rxok <= |(rdata & ISR_HP_RXOK);
                        rxhp_only <= |(rdata & ISR_HP_RXOK) && !(|(rdata & ISR_LP_RXOK));
                        if (|(rdata & ISR_TXOK)) begin
                            req <= 1'b1;
                            state <= ISR_RD_S0;
                        end else begin
                            state <= ISR_JUDGE;
                        end
                    end
                end
                ISR_RD_S0: begin
                    if (done) begin
                        txok_own <= (rdata == FPGA_QCU);
                        state <= ISR_JUDGE;
                    end
                end
                ISR_JUDGE: begin
                    owned <= own_match;
                    req <= 1'b1;
                    state <= own_match ? ISR_DISABLE : ISR_CLEAR;
                end
                ISR_DISABLE: begin
                    if (done) begin
                        req <= 1'b1;
                        state <= ISR_CLEAR;
                    end
                end
                ISR_CLEAR: begin
                    if (done && owned) begin
                        req <= 1'b1;
                        state <= ISR_ENABLE;
                    end else if (done) begin
                        // Host handles the rest
                        irq_out <= 1'b1;
                        state <= ISR_PASS;
                    end
                end
                ISR_ENABLE: begin
                    if (done) begin
                        clear_start <= 1'b1;
                        state <= ISR_PCIE;
                    end
                end
                ISR_PCIE: begin
                    if (clear_done) begin
                        state <= ISR_IDLE;
                    end
                end
                ISR_PASS: begin
                    if (!irq_in) begin
                        irq_out <= 1'b0;
                        state <= ISR_IDLE;
                    end
                end
                default: state <= ISR_IDLE;
            endcase
        end
    end

endmodule

/* logic/pcie_irq_clearer.sv */
module pcie_irq_clearer
    import irq_offload_pkg::*;
#(
    parameter addr_t PCIE_BASE = 32'h5000_0000
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      clear_start,
    input  logic      irq_in,
    output logic      clear_done,
    // Register bus request path
    output logic      req,
    output lite_req_t req_data,
    input  logic      grant,
    input  logic      done
);

    typedef enum logic [1:0] {
        PIRQ_IDLE,
        PIRQ_DECODE,
        PIRQ_FIFO
    } pirq_state_t;

    pirq_state_t state;

    // Decode ack first, then the FIFO register
    always_comb begin
        req_data.op = LITE_WRITE;
        if (state == PIRQ_FIFO) begin
            req_data.addr = PCIE_BASE + PCIE_INT_FIFO_REG1;
            req_data.data = PCIE_FIFO_ACK;
        end else begin
            req_data.addr = PCIE_BASE + PCIE_INT_DECODE;
            req_data.data = PCIE_DECODE_ACK;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= PIRQ_IDLE;
            req <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            if (grant) begin
                req <= 1'b0;
            end
            case (state)
                PIRQ_IDLE: begin
                    if (clear_start) begin
                        req <= 1'b1;
                        state <= PIRQ_DECODE;
                    end
                end
                PIRQ_DECODE: begin
                    if (done) begin
                        req <= 1'b1;
                        state <= PIRQ_FIFO;
                    end
                end
                PIRQ_FIFO: begin
                    // Line still up, acknowledge again
                    if (done && irq_in) begin
                        req <= 1'b1;
                        state <= PIRQ_DECODE;
                    end else if (done) begin
                        clear_done <= 1'b1;
                        state <= PIRQ_IDLE;
                    end
                end
                default: state <= PIRQ_IDLE;
            endcase
        end
    end

endmodule

/* logic/tx_fifo_forwarder.sv */
module tx_fifo_forwarder
    import irq_offload_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    // First-word fall-through FIFO
    input  logic      txf_empty,
    input  logic      txf_valid,
    input  data_t     txf_data,
    output logic      txf_rd_en,
    // Register bus request path
    output logic      req,
    output lite_req_t req_data,
    input  logic      grant,
    input  logic      done
);

    typedef enum logic [1:0] {
        TXF_IDLE,
        TXF_POP_ADDR,
        TXF_WAIT_DATA,
        TXF_WRITE
    } txf_state_t;

    txf_state_t state;
    addr_t      wr_addr;
    data_t      wr_data;
    logic       head_ok;

    assign head_ok = !txf_empty && txf_valid;

    assign req_data = '{op: LITE_WRITE, addr: wr_addr, data: wr_data};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= TXF_IDLE;
            txf_rd_en <= 1'b0;
            req <= 1'b0;
        end else begin
            txf_rd_en <= 1'b0;
            if (grant) begin
                req <= 1'b0;
            end
            case (state)
                TXF_IDLE: begin
                    if (head_ok) begin
                        txf_rd_en <= 1'b1;
                        state <= TXF_POP_ADDR;
                    end
                end
                // Head still shows the address during the pop
                TXF_POP_ADDR: state <= TXF_WAIT_DATA;
                TXF_WAIT_DATA: begin
                    if (head_ok) begin
                        txf_rd_en <= 1'b1;
                        req <= 1'b1;
                        state <= TXF_WRITE;
                    end
                end
                TXF_WRITE: begin
                    if (done) begin
                        state <= TXF_IDLE;
                    end
                end
                default: state <= TXF_IDLE;
            endcase
        end
    end

    // Address and data words of the pair
    always_ff @(posedge clk) begin
        if (state == TXF_IDLE && head_ok) begin
            wr_addr <= txf_data;
        end
        if (state == TXF_WAIT_DATA && head_ok) begin
            wr_data <= txf_data;
        end
    end

endmodule

/* logic/irq_offload_top.sv */
module irq_offload_top
    import irq_offload_pkg::*;
#(
    parameter addr_t CHIP_BASE = 32'h6000_0000,
    parameter addr_t PCIE_BASE = 32'h5000_0000,
    parameter data_t FPGA_QCU  = 32'h0000_0040
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      irq_in,
    output logic      irq_out,
    // TX FIFO
    input  logic      txf_empty,
    input  logic      txf_valid,
    input  data_t     txf_data,
    output logic      txf_rd_en,
    // Register bus
    output lite_req_t lite_req,
    output logic      lite_start,
    input  logic      lite_idle,
    input  logic      lite_done,
    input  data_t     lite_rdata
);

    // ------------------------------------------------------------
    // Request paths into the arbiter
    // ------------------------------------------------------------
    logic      irq_req;
    logic      irq_grant;
    logic      irq_done;
    lite_req_t irq_req_data;

    logic      txf_req;
    logic      txf_grant;
    logic      txf_done;
    lite_req_t txf_req_data;

    logic      pirq_req;
    logic      pirq_grant;
    logic      pirq_done;
    lite_req_t pirq_req_data;

    // ISR handler to PCIe clearer
    logic      clear_start;
    logic      clear_done;

    lite_bus_arbiter u_arbiter (
        .clk           (clk),
        .reset_n       (reset_n),
        .irq_req       (irq_req),
        .txf_req       (txf_req),
        .pirq_req      (pirq_req),
        .irq_req_data  (irq_req_data),
        .txf_req_data  (txf_req_data),
        .pirq_req_data (pirq_req_data),
        .irq_grant     (irq_grant),
        .txf_grant     (txf_grant),
        .pirq_grant    (pirq_grant),
        .irq_done      (irq_done),
        .txf_done      (txf_done),
        .pirq_done     (pirq_done),
        .lite_req      (lite_req),
        .lite_start    (lite_start),
        .lite_idle     (lite_idle),
        .lite_done     (lite_done)
    );

    isr_handler #(
        .CHIP_BASE (CHIP_BASE),
        .FPGA_QCU  (FPGA_QCU)
    ) u_isr_handler (
        .clk         (clk),
        .reset_n     (reset_n),
        .irq_in      (irq_in),
        .irq_out     (irq_out),
        .req         (irq_req),
        .req_data    (irq_req_data),
        .grant       (irq_grant),
        .done        (irq_done),
        .rdata       (lite_rdata),
        .clear_start (clear_start),
        .clear_done  (clear_done)
    );

    pcie_irq_clearer #(
        .PCIE_BASE (PCIE_BASE)
    ) u_pcie_irq_clearer (
        .clk         (clk),
        .reset_n     (reset_n),
        .clear_start (clear_start),
        .irq_in      (irq_in),
        .clear_done  (clear_done),
        .req         (pirq_req),
        .req_data    (pirq_req_data),
        .grant       (pirq_grant),
        .done        (pirq_done)
    );

    tx_fifo_forwarder u_tx_fifo_forwarder (
        .clk       (clk),
        .reset_n   (reset_n),
        .txf_empty (txf_empty),
        .txf_valid (txf_valid),
        .txf_data  (txf_data),
        .txf_rd_en (txf_rd_en),
        .req       (txf_req),
        .req_data  (txf_req_data),
        .grant     (txf_grant),
        .done      (txf_done)
    );

endmodule

/* tb/irq_offload_checker.sv */
module irq_offload_checker
    import irq_offload_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input lite_req_t lite_req,
    input logic      lite_start,
    input logic      lite_idle,
    input logic      lite_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Set from the cycle after a start until lite_done
    logic busy;
    int   fail_start = 0;
    int   fail_idle = 0;
    int   fail_overlap = 0;
    int   fail_hold = 0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
        end else if (lite_start) begin
            busy <= 1'b1;
        end else if (lite_done) begin
            busy <= 1'b0;
        end
    end

    start_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        lite_start |=> !lite_start)
        else begin
            $error("lite_start held for more than one cycle");
            fail_start++;
        end

    // Start is registered, so lite_idle was seen in the grant cycle
    start_when_idle: assert property (@(posedge clk) disable iff (!reset_n)
        lite_start |-> $past(lite_idle))
        else begin
            $error("lite_start issued while lite_idle was low");
            fail_idle++;
        end

    no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
        lite_start |-> !busy)
        else begin
            $error("lite_start issued before lite_done of the previous start");
            fail_overlap++;
        end

    req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        busy |-> $stable(lite_req))
        else begin
            $error("lite_req changed while a transaction was outstanding");
            fail_hold++;
        end

endmodule

bind irq_offload_top irq_offload_checker u_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .lite_req   (lite_req),
    .lite_start (lite_start),
    .lite_idle  (lite_idle),
    .lite_done  (lite_done)
);

/* tb/tb_top.sv */
module tb_top
    import irq_offload_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t CHIP_BASE = 32'h6000_0000;
    localparam addr_t PCIE_BASE = 32'h5000_0000;
    localparam data_t FPGA_QCU  = 32'h0000_0040;
    localparam int    TIMEOUT   = 3000;

    logic      clk = 1'b0;
    logic      reset_n = 1'b0;
    logic      irq_in = 1'b0;
    logic      irq_out;
    logic      txf_empty = 1'b1;
    logic      txf_valid = 1'b0;
    data_t     txf_data = '0;
    logic      txf_rd_en;
    lite_req_t lite_req;
    logic      lite_start;
    logic      lite_idle = 1'b1;
    logic      lite_done = 1'b0;
    data_t     lite_rdata = '0;

    // Device cases, 0 to 2 owned by the FPGA, the rest foreign
    data_t case_isr [0:7] = '{32'h8100_0001, 32'h8100_0041, 32'h0000_0040, 32'h0000_0040,
                              32'h0000_0003, 32'h8100_0003, 32'h0000_0010, 32'h8100_0041};
    data_t case_s0 [0:7] = '{32'h0, 32'h40, 32'h40, 32'h01, 32'h0, 32'h0, 32'h0, 32'h02};

    // Written by the stimulus thread only
    data_t     fifo_mem [0:255];
    int        fifo_wr = 0;
    int        fire_req = 0;
    data_t     dev_isr = '0;
    data_t     dev_s0 = '0;
    int        dev_holds = 0;
    lite_req_t irq_exp[$];
    lite_req_t tx_exp[$];

    // Written by the falling-edge models only
    int        fifo_rd = 0;
    int        fire_ack = 0;
    int        holds_left = 0;
    int        pass_cnt = 0;
    int        rd_pulses = 0;
    logic      bus_busy = 1'b0;
    int        bus_wait = 0;
    lite_req_t cur_req;
    lite_req_t irq_log[$];
    lite_req_t tx_log[$];

    int errors = 0;
    int errors_at_start = 0;
    int checks = 0;
    int tests = 0;
    int irq_base = 0;
    int tx_checked = 0;

    irq_offload_top #(
        .CHIP_BASE (CHIP_BASE),
        .PCIE_BASE (PCIE_BASE),
        .FPGA_QCU  (FPGA_QCU)
    ) UUT (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // FIFO, device and bus models
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (txf_rd_en) begin
            rd_pulses++;
            if (fifo_rd != fifo_wr) begin
                fifo_rd++;
            end
        end
        txf_empty = (fifo_rd == fifo_wr);
        txf_valid = !txf_empty;
        txf_data = txf_empty ? '0 : fifo_mem[fifo_rd];

        if (fire_ack != fire_req) begin
            fire_ack = fire_req;
            irq_in = 1'b1;
            holds_left = dev_holds;
            pass_cnt = 0;
        end else if (irq_in && irq_out) begin
            // Host side clears the source a few cycles later
            pass_cnt++;
            if (pass_cnt == 3) begin
                irq_in = 1'b0;
            end
        end

        lite_done = 1'b0;
        lite_rdata = '0;
        if (lite_start) begin
            cur_req = lite_req;
            bus_busy = 1'b1;
            bus_wait = 1 + int'($urandom % 6);
        end else if (bus_busy) begin
            bus_wait--;
            if (bus_wait == 0) begin
                lite_done = 1'b1;
                bus_busy = 1'b0;
                if (cur_req.addr[31:28] == 4'h1) begin
                    tx_log.push_back(cur_req);
                end else begin
                    irq_log.push_back(cur_req);
                end
                if (cur_req.op == LITE_READ && cur_req.addr == CHIP_BASE + AR_ISR) begin
                    lite_rdata = dev_isr;
                end else if (cur_req.op == LITE_READ) begin
                    lite_rdata = dev_s0;
                end
                if (cur_req.op == LITE_WRITE
                        && cur_req.addr == PCIE_BASE + PCIE_INT_FIFO_REG1) begin
                    if (holds_left > 0) begin
                        holds_left--;
                    end else begin
                        irq_in = 1'b0;
                    end
                end
            end
        end
        lite_idle = bus_busy ? 1'b0 : (($urandom % 4) != 0);
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name,
                 errors - errors_at_start);
        errors_at_start = errors;
    endtask

    function automatic lite_req_t make_req(lite_op_t op, addr_t addr, data_t data);
        lite_req_t r;
        r.op = op;
        r.addr = addr;
        r.data = data;
        return r;
    endfunction

    // Reads carry no data, so only op and address count
    task automatic compare_req(input lite_req_t got, input lite_req_t exp);
        check_val("lite_req.op", 32'(got.op), 32'(exp.op));
        check_val("lite_req.addr", got.addr, exp.addr);
        if (exp.op == LITE_WRITE) begin
            check_val("lite_req.data", got.data, exp.data);
        end
    endtask

    // Expected bus log of one interrupt
    task automatic build_expect(input data_t isr, input data_t s0, input int holds,
                                output logic own);
        logic  txok_own;
        logic  hp;
        logic  rxhp_only;
        data_t rx_set;
        data_t mask;
        int    i;
        rx_set = ISR_HP_RXOK | ISR_RXINTM | ISR_RXMINTR;
        txok_own = ((isr & ISR_TXOK) != 0) && (s0 == FPGA_QCU);
        hp = (isr & ISR_HP_RXOK) != 0;
        rxhp_only = hp && ((isr & ISR_LP_RXOK) == 0);
        mask = '0;
        if (txok_own) mask = mask | ISR_TXOK;
        if (hp) mask = mask | ISR_HP_RXOK;
        if (rxhp_only) mask = mask | ISR_RXINTM | ISR_RXMINTR;
        own = (hp && isr == rx_set) || (txok_own && isr == (rx_set | ISR_TXOK))
            || (txok_own && isr == ISR_TXOK);
        irq_exp.delete();
        irq_exp.push_back(make_req(LITE_READ, CHIP_BASE + AR_ISR, '0));
        if ((isr & ISR_TXOK) != 0) begin
            irq_exp.push_back(make_req(LITE_READ, CHIP_BASE + AR_ISR_S0, '0));
        end
        if (own) begin
            irq_exp.push_back(make_req(LITE_WRITE, CHIP_BASE + AR_IER, IER_DISABLE));
        end
        irq_exp.push_back(make_req(LITE_WRITE, CHIP_BASE + AR_ISR, mask));
        if (own) begin
            irq_exp.push_back(make_req(LITE_WRITE, CHIP_BASE + AR_IER, IER_ENABLE));
            for (i = 0; i <= holds; i++) begin
                irq_exp.push_back(make_req(LITE_WRITE, PCIE_BASE + PCIE_INT_DECODE,
                                           PCIE_DECODE_ACK));
                irq_exp.push_back(make_req(LITE_WRITE, PCIE_BASE + PCIE_INT_FIFO_REG1,
                                           PCIE_FIFO_ACK));
            end
        end
    endtask

    task automatic run_irq(input int idx, input int holds);
        logic own;
        int   t;
        int   i;
        irq_base = irq_log.size();
        dev_isr = case_isr[idx];
        dev_s0 = case_s0[idx];
        dev_holds = holds;
        build_expect(dev_isr, dev_s0, holds, own);
        fire_req++;
        t = 0;
        if (own) begin
            while (!(irq_log.size() - irq_base >= irq_exp.size() && !irq_in)
                    && t < TIMEOUT) begin
                tick();
                t++;
                check_val("irq_out", 32'(irq_out), 32'h0);
            end
            if (t >= TIMEOUT) report_timeout("owned interrupt sequence never finished");
            // Let the handler settle back to idle
            for (i = 0; i < 6; i++) begin
                tick();
                check_val("irq_out", 32'(irq_out), 32'h0);
            end
        end else begin
            while (!irq_out && t < TIMEOUT) begin
                tick();
                t++;
            end
            if (t >= TIMEOUT) report_timeout("irq_out never rose for a foreign interrupt");
            t = 0;
            while (irq_in && t < TIMEOUT) begin
                check_val("irq_out", 32'(irq_out), 32'h1);
                tick();
                t++;
            end
            if (t >= TIMEOUT) report_timeout("irq_in stayed high after irq_out rose");
            t = 0;
            while (irq_out && t < TIMEOUT) begin
                tick();
                t++;
            end
            if (t >= TIMEOUT) report_timeout("irq_out never fell after irq_in dropped");
        end
        checks++;
        assert (irq_log.size() - irq_base == irq_exp.size()) else begin
            $display("Interrupt %0d gave %0d bus transactions instead of %0d", idx,
                     irq_log.size() - irq_base, irq_exp.size());
            errors++;
        end
        for (i = 0; i < irq_exp.size() && irq_base + i < irq_log.size(); i++) begin
            compare_req(irq_log[irq_base + i], irq_exp[i]);
        end
    endtask

    task automatic push_pairs(input int n);
        data_t r;
        data_t addr;
        data_t data;
        int    i;
        for (i = 0; i < n; i++) begin
            r = $urandom;
            addr = {4'h1, r[27:0]};
            data = $urandom;
            fifo_mem[fifo_wr] = addr;
            fifo_mem[fifo_wr + 1] = data;
            fifo_wr = fifo_wr + 2;
            tx_exp.push_back(make_req(LITE_WRITE, addr, data));
        end
    endtask

    task automatic wait_tx(input int pulse_base, input int pairs);
        int t;
        int i;
        t = 0;
        while (tx_log.size() < tx_exp.size() && t < TIMEOUT) begin
            tick();
            t++;
        end
        if (t >= TIMEOUT) report_timeout("TX FIFO writes did not all reach the bus");
        check_val("tx write count", tx_log.size(), tx_exp.size());
        for (i = tx_checked; i < tx_exp.size() && i < tx_log.size(); i++) begin
            compare_req(tx_log[i], tx_exp[i]);
        end
        tx_checked = tx_exp.size();
        check_val("txf_rd_en pulses", rd_pulses - pulse_base, 2 * pairs);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        int base;
        void'($urandom(81356));
        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        for (i = 0; i < 30; i++) begin
            tick();
            check_val("lite_start", 32'(lite_start), 32'h0);
            check_val("txf_rd_en", 32'(txf_rd_en), 32'h0);
            check_val("irq_out", 32'(irq_out), 32'h0);
        end
        end_test("idle after reset");

        for (i = 0; i < 3; i++) run_irq(i, 0);
        end_test("owned interrupts");

        for (i = 3; i < 8; i++) run_irq(i, 0);
        end_test("foreign interrupts");

        run_irq(0, 1);
        run_irq(2, 2);
        end_test("repeated PCIe acknowledge");

        base = rd_pulses;
        push_pairs(20);
        wait_tx(base, 20);
        end_test("TX FIFO pairs");

        base = rd_pulses;
        push_pairs(16);
        for (i = 0; i < 6; i++) run_irq(int'($urandom % 8), int'($urandom % 3));
        wait_tx(base, 16);
        end_test("interleaved traffic");

        errors = errors + UUT.u_checker.fail_start + UUT.u_checker.fail_idle
               + UUT.u_checker.fail_overlap + UUT.u_checker.fail_hold;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
logic/irq_offload_pkg.sv
logic/lite_bus_arbiter.sv
logic/isr_handler.sv
logic/pcie_irq_clearer.sv
logic/tx_fifo_forwarder.sv
logic/irq_offload_top.sv
tb/irq_offload_checker.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator; the pass line decides the status
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_top -o sim_tb || exit 1

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Test OK" && exit 0 || exit 1
